//--- cpu_defines.svh
// core width and memory macros
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// data path and address width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// pc loaded by reset
`define RESET_PC 32'h0000_0000

// data memory depth in words
`define DMEM_WORDS 64

// address bit that selects the peripheral window
`define PER_SEL_BIT 30

`endif

//--- decodeStage.sv
// decode stage and register file
`timescale 1ns/1ns
`include "cpu_defines.svh"

module decodeStage
    import pipePkg::*, isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  ifId_s     ifId,
    input  logic      stall,
    input  logic      branchTaken,
    input  regWrite_s regWrite,
    output idEx_s     idEx,
    output redirect_s jumpRedirect
);

    instrWord_u       word;
    logic [`XLEN-1:0] regs [32];
    logic [`XLEN-1:0] imm;
    logic             destIsRd;
    logic             isJump;
    idEx_s            idExNext;

    assign word = ifId.word;
    assign imm  = {{(`XLEN-16){word.i.imm[15]}}, word.i.imm};

    // control decode, unknown codes give a bubble
    always_comb begin
        idExNext = '0;
        destIsRd = 1'b0;
        isJump   = 1'b0;
        case (word.r.opcode)
            OP_RTYPE: begin
                destIsRd             = 1'b1;
                idExNext.wb.regWrite = 1'b1;
                case (word.r.funct)
                    FN_ADD:  idExNext.ex.aluOp = ALU_ADD;
                    FN_SUB:  idExNext.ex.aluOp = ALU_SUB;
                    FN_AND:  idExNext.ex.aluOp = ALU_AND;
                    FN_OR:   idExNext.ex.aluOp = ALU_OR;
                    FN_SLT:  idExNext.ex.aluOp = ALU_SLT;
                    default: idExNext.wb.regWrite = 1'b0;
                endcase
            end
            OP_ADDI: begin
                idExNext.ex.useImm   = 1'b1;
                idExNext.wb.regWrite = 1'b1;
            end
            OP_LW: begin
                idExNext.ex.useImm   = 1'b1;
                idExNext.mem.memRead = 1'b1;
                idExNext.wb.regWrite = 1'b1;
                idExNext.wb.memToReg = 1'b1;
            end
            OP_SW: begin
                idExNext.ex.useImm    = 1'b1;
                idExNext.mem.memWrite = 1'b1;
            end
            OP_BEQ: begin
                idExNext.ex.aluOp  = ALU_SUB;
                idExNext.ex.branch = 1'b1;
            end
            OP_J:    isJump = 1'b1;
            default: ;
        endcase
        idExNext.rs   = word.i.rs;
        idExNext.rt   = word.i.rt;
        idExNext.dest = destIsRd ? word.r.rd : word.i.rt;
        // r0 reads zero, same-cycle writeback bypasses the array
        if (word.i.rs == '0) begin
            idExNext.opA = '0;
        end else if (regWrite.en && regWrite.idx == word.i.rs) begin
            idExNext.opA = regWrite.data;
        end else begin
            idExNext.opA = regs[word.i.rs];
        end
        if (word.i.rt == '0) begin
            idExNext.opB = '0;
        end else if (regWrite.en && regWrite.idx == word.i.rt) begin
            idExNext.opB = regWrite.data;
        end else begin
            idExNext.opB = regs[word.i.rt];
        end
        idExNext.imm          = imm;
        idExNext.branchTarget = ifId.pcPlus4 + {imm[`XLEN-3:0], 2'b00};
    end

    always_ff @(posedge clk) begin
        if (regWrite.en) begin
            regs[regWrite.idx] <= regWrite.data;
        end
    end

    // jump target keeps the upper pc+4 nibble
    assign jumpRedirect.take   = isJump;
    assign jumpRedirect.target = {ifId.pcPlus4[`XLEN-1:28], word.i.rs, word.i.rt,
                                  word.i.imm, 2'b00};

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            idEx <= '0;
        end else if (stall || branchTaken) begin
            idEx <= '0;
        end else begin
            idEx <= idExNext;
        end
    end

endmodule

//--- executeStage.sv
// execute stage with alu and branch compare
`timescale 1ns/1ns
`include "cpu_defines.svh"

module executeStage
    import pipePkg::*, isaPkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  idEx_s     idEx,
    input  fwdSel_e   forwardA,
    input  fwdSel_e   forwardB,
    input  regWrite_s exMemFwd,
    input  regWrite_s memWbFwd,
    output exMem_s    exMem,
    output redirect_s branchRedirect
);

    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic [`XLEN-1:0] aluB;
    logic [`XLEN-1:0] aluResult;

    // operand muxes
    always_comb begin
        case (forwardA)
            FWD_EXMEM: srcA = exMemFwd.data;
            FWD_MEMWB: srcA = memWbFwd.data;
            default:   srcA = idEx.opA;
        endcase
        case (forwardB)
            FWD_EXMEM: srcB = exMemFwd.data;
            FWD_MEMWB: srcB = memWbFwd.data;
            default:   srcB = idEx.opB;
        endcase
    end

    assign aluB = idEx.ex.useImm ? idEx.imm : srcB;

    always_comb begin
        case (idEx.ex.aluOp)
            ALU_SUB: aluResult = srcA - aluB;
            ALU_AND: aluResult = srcA & aluB;
            ALU_OR:  aluResult = srcA | aluB;
            // signed compare, 1 or 0
            ALU_SLT: aluResult = {{(`XLEN-1){1'b0}}, $signed(srcA) < $signed(aluB)};
            default: aluResult = srcA + aluB;
        endcase
    end

    // beq taken on equal forwarded operands
    assign branchRedirect.take   = idEx.ex.branch && (srcA == srcB);
    assign branchRedirect.target = idEx.branchTarget;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            exMem <= '0;
        end else begin
            exMem.mem       <= idEx.mem;
            exMem.wb        <= idEx.wb;
            exMem.aluResult <= aluResult;
            // store data takes the forwarded rt value
            exMem.storeData <= srcB;
            exMem.dest      <= idEx.dest;
        end
    end

endmodule

//--- fetchStage.sv
// instruction fetch stage
`timescale 1ns/1ns
`include "cpu_defines.svh"

module fetchStage
    import pipePkg::*, isaPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  logic             stall,
    input  redirect_s        branchRedirect,
    input  redirect_s        jumpRedirect,
    input  instrWord_u       instr,
    output logic [`XLEN-1:0] pc,
    output ifId_s            ifId
);

    logic [`XLEN-1:0] pcPlus4;

    assign pcPlus4 = pc + `XLEN'd4;

    // branch beats jump beats stall
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc <= `RESET_PC;
        end else if (branchRedirect.take) begin
            pc <= branchRedirect.target;
        end else if (jumpRedirect.take) begin
            pc <= jumpRedirect.target;
        end else if (!stall) begin
            pc <= pcPlus4;
        end
    end

    // zero word decodes as a nop
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            ifId <= '0;
        end else if (branchRedirect.take || jumpRedirect.take) begin
            ifId <= '0;
        end else if (!stall) begin
            ifId.pcPlus4 <= pcPlus4;
            ifId.word    <= instr;
        end
    end

endmodule

//--- hazardUnit.sv
// load-use and forwarding control
`timescale 1ns/1ns
`include "cpu_defines.svh"

module hazardUnit
    import pipePkg::*, isaPkg::*;
(
    input  instrWord_u ifIdWord,
    input  idEx_s      idEx,
    input  regWrite_s  exMemFwd,
    input  regWrite_s  memWbFwd,
    output logic       stall,
    output fwdSel_e    forwardA,
    output fwdSel_e    forwardB
);

    // youngest producer wins, r0 never forwarded
    function automatic fwdSel_e pickFwd(input logic [`REG_ADDR_W-1:0] src,
                                        input regWrite_s exMemSrc,
                                        input regWrite_s memWbSrc);
        if (exMemSrc.en && exMemSrc.idx != '0 && exMemSrc.idx == src) begin
            return FWD_EXMEM;
        end else if (memWbSrc.en && memWbSrc.idx != '0 && memWbSrc.idx == src) begin
            return FWD_MEMWB;
        end
        return FWD_REG;
    endfunction

    // load in execute feeding the word in decode
    assign stall = idEx.mem.memRead && idEx.dest != '0 &&
                   (idEx.dest == ifIdWord.i.rs || idEx.dest == ifIdWord.i.rt);

    assign forwardA = pickFwd(idEx.rs, exMemFwd, memWbFwd);
    assign forwardB = pickFwd(idEx.rt, exMemFwd, memWbFwd);

endmodule

//--- isaPkg.sv
// instruction set encodings
`include "cpu_defines.svh"

package isaPkg;

    // primary opcodes of the kept instructions
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    // r-type function field
    typedef enum logic [5:0] {
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } funct_e;

    // alu operation, zero value is add
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_e;

    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] rd;
        logic [4:0]             shamt;
        funct_e                 funct;
    } rType_s;

    // low 26 bits double as the jump index
    typedef struct packed {
        opcode_e                opcode;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [15:0]            imm;
    } iType_s;

    // one fetched word, two views
    typedef union packed {
        rType_s r;
        iType_s i;
    } instrWord_u;

endpackage

//--- memoryStage.sv
// memory access and writeback select
`timescale 1ns/1ns
`include "cpu_defines.svh"

module memoryStage
    import pipePkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  exMem_s           exMem,
    input  logic [`XLEN-1:0] perRdData,
    output perBus_s          perBus,
    output regWrite_s        exMemFwd,
    output regWrite_s        regWrite
);

    localparam int IDX_W = $clog2(`DMEM_WORDS);

    logic [`XLEN-1:0] dmem [`DMEM_WORDS];
    logic             isPer;
    logic [IDX_W-1:0] wordIdx;
    logic [`XLEN-1:0] loadData;
    memWb_s           memWb;

    // bit 30 picks the peripheral window
    assign isPer   = exMem.aluResult[`PER_SEL_BIT];
    assign wordIdx = exMem.aluResult[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (exMem.mem.memWrite && !isPer) begin
            dmem[wordIdx] <= exMem.storeData;
        end
    end

    assign loadData = isPer ? perRdData : dmem[wordIdx];

    // plain strobes, valid in this cycle only
    assign perBus.wr    = exMem.mem.memWrite && isPer;
    assign perBus.rd    = exMem.mem.memRead && isPer;
    assign perBus.addr  = exMem.aluResult;
    assign perBus.wdata = exMem.storeData;

    assign exMemFwd.en   = exMem.wb.regWrite;
    assign exMemFwd.idx  = exMem.dest;
    assign exMemFwd.data = exMem.aluResult;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            memWb <= '0;
        end else begin
            memWb.wb        <= exMem.wb;
            memWb.aluResult <= exMem.aluResult;
            memWb.loadData  <= loadData;
            memWb.dest      <= exMem.dest;
        end
    end

    // writeback port back to decode
    assign regWrite.en   = memWb.wb.regWrite;
    assign regWrite.idx  = memWb.dest;
    assign regWrite.data = memWb.wb.memToReg ? memWb.loadData : memWb.aluResult;

endmodule

//--- pipePkg.sv
// pipeline register and bus types
`include "cpu_defines.svh"

package pipePkg;
    import isaPkg::*;

    typedef struct packed {
        logic [`XLEN-1:0] pcPlus4;
        instrWord_u       word;
    } ifId_s;

    typedef struct packed {
        aluOp_e aluOp;
        logic   useImm;
        logic   branch;
    } exCtrl_s;

    typedef struct packed {
        logic memRead;
        logic memWrite;
    } memCtrl_s;

    typedef struct packed {
        logic regWrite;
        logic memToReg;
    } wbCtrl_s;

    // all-zero control is a bubble
    typedef struct packed {
        exCtrl_s                ex;
        memCtrl_s               mem;
        wbCtrl_s                wb;
        logic [`REG_ADDR_W-1:0] rs;
        logic [`REG_ADDR_W-1:0] rt;
        logic [`REG_ADDR_W-1:0] dest;
        logic [`XLEN-1:0]       opA;
        logic [`XLEN-1:0]       opB;
        logic [`XLEN-1:0]       imm;
        logic [`XLEN-1:0]       branchTarget;
    } idEx_s;

    typedef struct packed {
        memCtrl_s               mem;
        wbCtrl_s                wb;
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       storeData;
        logic [`REG_ADDR_W-1:0] dest;
    } exMem_s;

    typedef struct packed {
        wbCtrl_s                wb;
        logic [`XLEN-1:0]       aluResult;
        logic [`XLEN-1:0]       loadData;
        logic [`REG_ADDR_W-1:0] dest;
    } memWb_s;

    // register write port, also used for forwarding
    typedef struct packed {
        logic                   en;
        logic [`REG_ADDR_W-1:0] idx;
        logic [`XLEN-1:0]       data;
    } regWrite_s;

    typedef struct packed {
        logic             take;
        logic [`XLEN-1:0] target;
    } redirect_s;

    typedef enum logic [1:0] {
        FWD_REG   = 2'b00,
        FWD_MEMWB = 2'b01,
        FWD_EXMEM = 2'b10
    } fwdSel_e;

    typedef struct packed {
        logic             wr;
        logic             rd;
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] wdata;
    } perBus_s;

endpackage

//--- pipelineCpu.sv
// five-stage pipelined core
`timescale 1ns/1ns
`include "cpu_defines.svh"

module pipelineCpu
    import pipePkg::*, isaPkg::*;
(
    input  logic             clk,
    input  logic             reset,
    input  instrWord_u       instr,
    input  logic [`XLEN-1:0] perRdData,
    output logic [`XLEN-1:0] pc,
    output perBus_s          perBus
);

    ifId_s     ifId;
    idEx_s     idEx;
    exMem_s    exMem;
    regWrite_s regWrite;
    regWrite_s exMemFwd;
    redirect_s branchRedirect;
    redirect_s jumpRedirect;
    logic      stall;
    fwdSel_e   forwardA;
    fwdSel_e   forwardB;

    fetchStage fetchStage_inst (
        .clk            (clk),
        .reset          (reset),
        .stall          (stall),
        .branchRedirect (branchRedirect),
        .jumpRedirect   (jumpRedirect),
        .instr          (instr),
        .pc             (pc),
        .ifId           (ifId)
    );

    decodeStage decodeStage_inst (
        .clk          (clk),
        .reset        (reset),
        .ifId         (ifId),
        .stall        (stall),
        .branchTaken  (branchRedirect.take),
        .regWrite     (regWrite),
        .idEx         (idEx),
        .jumpRedirect (jumpRedirect)
    );

    // writeback port doubles as the mem/wb forward
    hazardUnit hazardUnit_inst (
        .ifIdWord (ifId.word),
        .idEx     (idEx),
        .exMemFwd (exMemFwd),
        .memWbFwd (regWrite),
        .stall    (stall),
        .forwardA (forwardA),
        .forwardB (forwardB)
    );

    executeStage executeStage_inst (
        .clk            (clk),
        .reset          (reset),
        .idEx           (idEx),
        .forwardA       (forwardA),
        .forwardB       (forwardB),
        .exMemFwd       (exMemFwd),
        .memWbFwd       (regWrite),
        .exMem          (exMem),
        .branchRedirect (branchRedirect)
    );

    memoryStage memoryStage_inst (
        .clk       (clk),
        .reset     (reset),
        .exMem     (exMem),
        .perRdData (perRdData),
        .perBus    (perBus),
        .exMemFwd  (exMemFwd),
        .regWrite  (regWrite)
    );

endmodule

//--- pipelineCpuTb.sv
// pipelined core testbench
`timescale 1ns/1ns
`include "cpu_defines.svh"

module pipelineCpuTb
    import pipePkg::*, isaPkg::*;
();

    localparam int progCount   = 4;
    localparam int romDepth    = 32;
    localparam int writeDepth  = 8;
    localparam int waitLimit   = 40;
    localparam int drainCycles = 12;

    // encodings written out from the isa
    localparam logic [5:0] opAddi = 6'h08;
    localparam logic [5:0] opLw   = 6'h23;
    localparam logic [5:0] opSw   = 6'h2b;
    localparam logic [5:0] opBeq  = 6'h04;
    localparam logic [5:0] opJ    = 6'h02;
    localparam logic [5:0] fnAdd  = 6'h20;
    localparam logic [5:0] fnSub  = 6'h22;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    logic             clk;
    logic             reset;
    logic [`XLEN-1:0] perRdData;
    logic [`XLEN-1:0] pc;
    perBus_s          perBus;
    instrWord_u       romWord;
    logic [1:0]       curProg;
    logic [1:0]       buildProg;
    logic [31:0]      lfsrState;
    int               valueErrors;
    int               otherErrors;

    // program table with the expected peripheral writes
    logic [31:0] progRom    [progCount][romDepth];
    int          progLen    [progCount];
    int          wrCount    [progCount];
    logic [31:0] expAddr    [progCount][writeDepth];
    logic [31:0] expData    [progCount][writeDepth];
    logic        expPlusPer [progCount][writeDepth];
    logic        expRd      [progCount];

    pipelineCpu pipelineCpu_inst (
        .clk       (clk),
        .reset     (reset),
        .instr     (romWord),
        .perRdData (perRdData),
        .pc        (pc),
        .perBus    (perBus)
    );

    always #4 clk = ~clk;

    // rom answers in the same cycle, nop past the end
    always_comb begin
        if ((pc >> 2) < 32'(progLen[curProg])) begin
            romWord = progRom[curProg][pc[6:2]];
        end else begin
            romWord = '0;
        end
    end

    function automatic logic [31:0] encodeR(input logic [5:0] fn, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        return {6'h00, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] encodeJump(input logic [25:0] index);
        return {opJ, index};
    endfunction

    // galois lfsr, right shift, x^32+x^22+x^2+x+1
    function automatic logic [31:0] stepLfsr(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic drawWord(output logic [31:0] value);
        value = '0;
        for (int b = 0; b < 32; b++) begin
            value     = {value[30:0], lfsrState[0]};
            lfsrState = stepLfsr(lfsrState);
        end
    endtask

    task automatic addWord(input logic [31:0] word);
        progRom[buildProg][5'(progLen[buildProg])] = word;
        progLen[buildProg] = progLen[buildProg] + 1;
    endtask

    // plusPer adds the drawn peripheral input to data
    task automatic addWrite(input logic [31:0] addr, input logic [31:0] data,
                            input logic plusPer);
        expAddr[buildProg][3'(wrCount[buildProg])]    = addr;
        expData[buildProg][3'(wrCount[buildProg])]    = data;
        expPlusPer[buildProg][3'(wrCount[buildProg])] = plusPer;
        wrCount[buildProg] = wrCount[buildProg] + 1;
    endtask

    task automatic loadPrograms();
        for (int p = 0; p < progCount; p++) begin
            progLen[2'(p)] = 0;
            wrCount[2'(p)] = 0;
            expRd[2'(p)]   = 1'b0;
        end
        // forwarding chain, r7 is the peripheral base 0xffff8000
        buildProg = 2'd0;
        addWord(encodeI(opAddi, 5'd0, 5'd7, 16'h8000));
        addWord(encodeI(opAddi, 5'd0, 5'd1, 16'd5));
        addWord(encodeI(opAddi, 5'd1, 5'd2, 16'd7));
        addWord(encodeR(fnAdd, 5'd2, 5'd1, 5'd3));
        addWord(encodeR(fnSub, 5'd3, 5'd2, 5'd4));
        addWord(encodeR(fnAnd, 5'd4, 5'd3, 5'd5));
        addWord(encodeR(fnOr, 5'd5, 5'd4, 5'd6));
        addWord(encodeR(fnSlt, 5'd6, 5'd3, 5'd8));
        // r9 in both ex/mem and mem/wb, younger one must win
        addWord(encodeI(opAddi, 5'd0, 5'd9, 16'hfffe));
        addWord(encodeI(opAddi, 5'd9, 5'd9, 16'd10));
        addWord(encodeR(fnAdd, 5'd9, 5'd9, 5'd10));
        // negative against positive for signed slt
        addWord(encodeR(fnSub, 5'd0, 5'd3, 5'd12));
        addWord(encodeR(fnSlt, 5'd12, 5'd4, 5'd13));
        addWord(encodeI(opSw, 5'd7, 5'd3, 16'd0));
        addWord(encodeI(opSw, 5'd7, 5'd4, 16'd4));
        addWord(encodeI(opSw, 5'd7, 5'd5, 16'd8));
        addWord(encodeI(opSw, 5'd7, 5'd6, 16'd12));
        addWord(encodeI(opSw, 5'd7, 5'd8, 16'd16));
        addWord(encodeI(opSw, 5'd7, 5'd10, 16'd20));
        addWord(encodeI(opSw, 5'd7, 5'd12, 16'd24));
        addWord(encodeI(opSw, 5'd7, 5'd13, 16'd28));
        addWrite(32'hffff_8000, 32'h0000_0011, 1'b0);
        addWrite(32'hffff_8004, 32'h0000_0005, 1'b0);
        addWrite(32'hffff_8008, 32'h0000_0001, 1'b0);
        addWrite(32'hffff_800c, 32'h0000_0005, 1'b0);
        addWrite(32'hffff_8010, 32'h0000_0001, 1'b0);
        addWrite(32'hffff_8014, 32'h0000_0010, 1'b0);
        addWrite(32'hffff_8018, 32'hffff_ffef, 1'b0);
        addWrite(32'hffff_801c, 32'h0000_0001, 1'b0);
        // load-use through data memory
        buildProg = 2'd1;
        addWord(encodeI(opAddi, 5'd0, 5'd7, 16'h8000));
        addWord(encodeI(opAddi, 5'd0, 5'd1, 16'h0123));
        addWord(encodeI(opSw, 5'd0, 5'd1, 16'd8));
        addWord(encodeI(opLw, 5'd0, 5'd2, 16'd8));
        addWord(encodeR(fnAdd, 5'd2, 5'd1, 5'd3));
        addWord(encodeI(opSw, 5'd7, 5'd3, 16'd0));
        addWrite(32'hffff_8000, 32'h0000_0246, 1'b0);
        // peripheral load then addi 5
        buildProg = 2'd2;
        addWord(encodeI(opAddi, 5'd0, 5'd7, 16'h8000));
        addWord(encodeI(opLw, 5'd7, 5'd3, 16'd4));
        addWord(encodeI(opAddi, 5'd3, 5'd4, 16'd5));
        addWord(encodeI(opSw, 5'd7, 5'd4, 16'd8));
        addWrite(32'hffff_8008, 32'd5, 1'b1);
        expRd[2'd2] = 1'b1;
        // branches and jump, marker stores sit on the wrong path
        buildProg = 2'd3;
        addWord(encodeI(opAddi, 5'd0, 5'd7, 16'h8000));
        addWord(encodeI(opAddi, 5'd0, 5'd1, 16'd3));
        addWord(encodeI(opAddi, 5'd0, 5'd2, 16'd3));
        addWord(encodeI(opBeq, 5'd1, 5'd2, 16'd2));
        addWord(encodeI(opSw, 5'd7, 5'd1, 16'h0070));
        addWord(encodeI(opSw, 5'd7, 5'd1, 16'h0074));
        addWord(encodeI(opSw, 5'd7, 5'd2, 16'd0));
        addWord(encodeI(opBeq, 5'd1, 5'd0, 16'd1));
        addWord(encodeI(opSw, 5'd7, 5'd1, 16'd4));
        addWord(encodeJump(26'd12));
        addWord(encodeI(opSw, 5'd7, 5'd1, 16'h0078));
        addWord(encodeI(opSw, 5'd7, 5'd1, 16'h007c));
        addWord(encodeI(opAddi, 5'd1, 5'd3, 16'd4));
        addWord(encodeI(opSw, 5'd7, 5'd3, 16'd8));
        addWrite(32'hffff_8000, 32'd3, 1'b0);
        addWrite(32'hffff_8004, 32'd3, 1'b0);
        addWrite(32'hffff_8008, 32'd7, 1'b0);
    endtask

    task automatic applyReset(input logic [1:0] prog, input logic [31:0] perVal);
        @(posedge clk);
        reset     <= 1'b0;
        curProg   <= prog;
        perRdData <= perVal;
        repeat (3) @(posedge clk);
        reset <= 1'b1;
        // half a cycle after release, core still at reset state
        @(negedge clk);
        assert (pc == `RESET_PC) else begin
            $display("ERR pc got %h expected %h", pc, `RESET_PC);
            valueErrors++;
        end
        assert (!perBus.wr) else begin
            $display("ERR perBus.wr got %h expected %h", perBus.wr, 1'b0);
            valueErrors++;
        end
        assert (!perBus.rd) else begin
            $display("ERR perBus.rd got %h expected %h", perBus.rd, 1'b0);
            valueErrors++;
        end
    endtask

    task automatic runProgram(input logic [1:0] prog);
        logic [31:0] perVal;
        logic [31:0] wantData;
        logic        sawRd;
        logic        found;
        int          cycles;
        int          w;
        drawWord(perVal);
        applyReset(prog, perVal);
        sawRd = 1'b0;
        for (w = 0; w < wrCount[prog]; w++) begin
            found  = 1'b0;
            cycles = 0;
            // bus sampled mid-cycle where it is stable
            while (!found && cycles < waitLimit) begin
                @(negedge clk);
                cycles++;
                sawRd = sawRd | perBus.rd;
                found = perBus.wr;
            end
            assert (found) else begin
                $display("timeout: program %0d never made peripheral write %0d", prog, w);
                otherErrors++;
            end
            if (!found) begin
                break;
            end
            wantData = expData[prog][3'(w)] + (expPlusPer[prog][3'(w)] ? perVal : 32'd0);
            assert (perBus.addr == expAddr[prog][3'(w)]) else begin
                $display("ERR perBus.addr got %h expected %h", perBus.addr,
                         expAddr[prog][3'(w)]);
                valueErrors++;
            end
            assert (perBus.wdata == wantData) else begin
                $display("ERR perBus.wdata got %h expected %h", perBus.wdata, wantData);
                valueErrors++;
            end
        end
        // nothing more on the bus once the program is done
        repeat (drainCycles) begin
            @(negedge clk);
            sawRd = sawRd | perBus.rd;
            assert (!perBus.wr) else begin
                $display("program %0d made an extra peripheral write to %h", prog, perBus.addr);
                otherErrors++;
            end
        end
        assert (sawRd == expRd[prog]) else begin
            $display("ERR perBus.rd got %h expected %h", sawRd, expRd[prog]);
            valueErrors++;
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b0;
        perRdData   = '0;
        curProg     = '0;
        buildProg   = '0;
        lfsrState   = 32'd21;
        valueErrors = 0;
        otherErrors = 0;
        loadPrograms();
        for (int p = 0; p < progCount; p++) begin
            runProgram(2'(p));
        end
        $display("value errors %0d, other errors %0d", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f --top-module pipelineCpuTb > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/VpipelineCpuTb > sim.log 2>&1
if [ $? -ne 0 ]; then
    cat sim.log
    echo "simulation exited with an error status"
    exit 1
fi
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

//--- vlog.f
+incdir+.
isaPkg.sv
pipePkg.sv
fetchStage.sv
decodeStage.sv
hazardUnit.sv
executeStage.sv
memoryStage.sv
pipelineCpu.sv
pipelineCpuTb.sv
